//--- Bender.yml
package:
  name: uart_rs232

sources:
  - include_dirs:
      - source
    files:
      - source/uart_types_pkg.sv
      - source/uart_state_pkg.sv
      - source/bit_timer.sv
      - source/tx_serializer.sv
      - source/rx_deserializer.sv
      - source/rx_fifo.sv
      - source/uart_control.sv
      - source/uart_top.sv

  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_uart_top.sv

//--- compile.f
+incdir+source
source/uart_types_pkg.sv
source/uart_state_pkg.sv
source/bit_timer.sv
source/tx_serializer.sv
source/rx_deserializer.sv
source/rx_fifo.sv
source/uart_control.sv
source/uart_top.sv
testbench/tb_clock_gen.sv
testbench/tb_uart_top.sv

//--- source/bit_timer.sv
// bit period timer
`include "uart_settings.svh"

module bit_timer
(
    input  logic clk,
    input  logic rst,
    input  logic run,           // count while high, hold at zero while low
    output logic mid_tick,
    output logic end_tick
);

    localparam uart_types_pkg::tick_count_t MID_COUNT =
        uart_types_pkg::tick_count_t'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam uart_types_pkg::tick_count_t END_COUNT =
        uart_types_pkg::tick_count_t'(`UART_CLKS_PER_BIT - 1);

    uart_types_pkg::tick_count_t count;

    always_ff @(posedge clk)
    begin
        if (rst)
            count <= '0;
        else if (!run)
            count <= '0;
        else if (count == END_COUNT)
            count <= '0;                // next bit period
        else
            count <= count + 1'b1;
    end

    assign mid_tick = (count == MID_COUNT);
    assign end_tick = (count == END_COUNT);

    // the controller may only drop run once the count has wrapped
    // or right after a mid tick, so a stale end count never shows up
    a_no_end_when_stopped : assert property (
        @(posedge clk) disable iff (rst)
        !run |-> !end_tick
    );

endmodule

//--- source/rx_deserializer.sv
// receive line sampler and frame checker
`include "uart_settings.svh"

module rx_deserializer
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rx,
    input  logic                  sample_data,
    input  logic                  sample_parity,
    input  logic                  sample_stop,
    output logic                  line_level,   // synchronized rx
    output uart_types_pkg::data_t data,
    output logic                  byte_valid,
    output logic                  frame_err
);

    localparam int DATA_BITS   = `UART_DATA_BITS;
    localparam int PARITY_MODE = `UART_PARITY_MODE;

    logic [1:0] rx_sync;
    logic       parity_acc;                     // xor of all sampled bits
    logic       parity_ok;

    // two flop synchronizer, resets to idle high
    always_ff @(posedge clk)
    begin
        if (rst)
            rx_sync <= 2'b11;
        else
            rx_sync <= {rx_sync[0], rx};
    end

    assign line_level = rx_sync[1];

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk)
    begin
        if (sample_data)
            data <= {line_level, data[DATA_BITS-1:1]};
    end

    always_comb
    begin
        case (PARITY_MODE)
            `UART_PARITY_EVEN: parity_ok = ~parity_acc;
            `UART_PARITY_ODD:  parity_ok = parity_acc;
            default:           parity_ok = 1'b1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            parity_acc <= 1'b0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end
        else
        begin
            byte_valid <= sample_stop && parity_ok && line_level;
            frame_err  <= sample_stop && !(parity_ok && line_level);
            if (sample_stop)
                parity_acc <= 1'b0;             // ready for the next frame
            else if (sample_data || sample_parity)
                parity_acc <= parity_acc ^ line_level;
        end
    end

    // one bit of the frame per strobe, a second strobe would corrupt the parity
    a_one_sample_strobe : assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({sample_data, sample_parity, sample_stop})
    );

endmodule

//--- source/rx_fifo.sv
// receive byte buffer
`include "uart_settings.svh"

module rx_fifo
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  uart_types_pkg::data_t push_data,
    input  logic                  pop,
    output uart_types_pkg::data_t head_data,
    output logic                  not_empty,
    output logic                  overflow
);

    localparam int COUNT_W = $clog2(`UART_FIFO_DEPTH) + 1;
    localparam logic [COUNT_W-1:0] FULL_COUNT = COUNT_W'(`UART_FIFO_DEPTH);

    uart_types_pkg::data_t      mem [`UART_FIFO_DEPTH];
    uart_types_pkg::fifo_addr_t wr_ptr;
    uart_types_pkg::fifo_addr_t rd_ptr;
    logic [COUNT_W-1:0]         count;
    logic                       full;
    logic                       push_ok;
    logic                       pop_ok;

    assign full      = (count == FULL_COUNT);
    assign not_empty = (count != '0);
    assign pop_ok    = pop && not_empty;        // pop on empty is ignored
    assign push_ok   = push && (!full || pop_ok);
    assign head_data = mem[rd_ptr];             // first word falls through

    always_ff @(posedge clk)
    begin
        if (push_ok)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            overflow <= push && !push_ok;       // byte dropped
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_in_range : assert property (
        @(posedge clk) disable iff (rst)
        count <= FULL_COUNT
    );

endmodule

//--- source/tx_serializer.sv
// transmit frame shifter
`include "uart_settings.svh"

module tx_serializer
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,     // capture data and build the frame
    input  logic                  shift,    // move the next bit onto the line
    input  uart_types_pkg::data_t data,
    output logic                  tx
);

    localparam int FRAME_BITS  = `UART_FRAME_BITS;
    localparam int DATA_BITS   = `UART_DATA_BITS;
    localparam int PARITY_MODE = `UART_PARITY_MODE;

    logic [FRAME_BITS-1:0] frame_init;
    logic [FRAME_BITS-1:0] frame_q;
    logic                  parity_bit;

    ////////////////////
    // frame image, bit 0 goes out first

    always_comb
    begin
        if (PARITY_MODE == `UART_PARITY_ODD)
            parity_bit = ~(^data);
        else
            parity_bit = ^data;             // even
    end

    always_comb
    begin
        frame_init = '1;                    // stop bits and idle fill
        frame_init[0] = 1'b0;               // start bit
        frame_init[DATA_BITS:1] = data;
        if (PARITY_MODE != `UART_PARITY_NONE)
            frame_init[DATA_BITS+1] = parity_bit;
    end

    ////////////////////
    // shift register and line driver

    always_ff @(posedge clk)
    begin
        if (load)
            frame_q <= frame_init;
        else if (shift)
            frame_q <= {1'b1, frame_q[FRAME_BITS-1:1]};  // refill with idle level
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            tx <= 1'b1;                     // line idles high
        else if (shift)
            tx <= frame_q[0];
    end

endmodule

//--- source/uart_control.sv
// UART transmit and receive sequencing
`include "uart_settings.svh"

module uart_control
(
    input  logic clk,
    input  logic rst,
    // transmit side
    input  logic tx_valid,
    output logic tx_accept,
    output logic tx_busy,
    output logic tx_run,
    output logic tx_load,
    output logic tx_shift,
    input  logic tx_mid_tick,
    input  logic tx_end_tick,
    // receive side
    output logic rx_run,
    input  logic rx_mid_tick,
    input  logic line_level,
    output logic sample_data,
    output logic sample_parity,
    output logic sample_stop
);

    localparam uart_types_pkg::bit_count_t TX_LAST_BIT =
        uart_types_pkg::bit_count_t'(`UART_FRAME_BITS - 1);
    localparam uart_types_pkg::bit_count_t RX_LAST_DATA =
        uart_types_pkg::bit_count_t'(`UART_DATA_BITS - 1);
    localparam bit HAS_PARITY = (`UART_PARITY_MODE != `UART_PARITY_NONE);

    uart_state_pkg::tx_state_t  tx_state;
    uart_state_pkg::rx_state_t  rx_state;
    uart_types_pkg::bit_count_t tx_bit_cnt;
    uart_types_pkg::bit_count_t rx_bit_cnt;

    ////////////////////
    // transmit FSM

    assign tx_load  = (tx_state == uart_state_pkg::tx_idle) && tx_valid;
    assign tx_busy  = (tx_state != uart_state_pkg::tx_idle);
    // timer starts with the start bit, one cycle after the accept
    assign tx_run   = (tx_state == uart_state_pkg::tx_frame) && !tx_accept;
    // the accept cycle puts the start bit out, then one shift per bit end
    assign tx_shift = tx_accept || ((tx_state == uart_state_pkg::tx_frame) && tx_end_tick);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tx_state   <= uart_state_pkg::tx_idle;
            tx_accept  <= 1'b0;
            tx_bit_cnt <= '0;
        end
        else
        begin
            tx_accept <= tx_load;
            case (tx_state)
                uart_state_pkg::tx_idle:
                begin
                    tx_bit_cnt <= '0;
                    if (tx_valid)
                        tx_state <= uart_state_pkg::tx_frame;
                end
                uart_state_pkg::tx_frame:
                begin
                    if (tx_end_tick)
                    begin
                        if (tx_bit_cnt == TX_LAST_BIT)
                            tx_state <= uart_state_pkg::tx_done;   // last stop bit over
                        else
                            tx_bit_cnt <= tx_bit_cnt + 1'b1;
                    end
                end
                default:
                    tx_state <= uart_state_pkg::tx_idle;
            endcase
        end
    end

    ////////////////////
    // receive FSM

    assign rx_run        = (rx_state != uart_state_pkg::rx_idle);
    assign sample_data   = (rx_state == uart_state_pkg::rx_data) && rx_mid_tick;
    assign sample_parity = (rx_state == uart_state_pkg::rx_parity) && rx_mid_tick;
    assign sample_stop   = (rx_state == uart_state_pkg::rx_stop) && rx_mid_tick;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_state   <= uart_state_pkg::rx_idle;
            rx_bit_cnt <= '0;
        end
        else
        begin
            case (rx_state)
                uart_state_pkg::rx_idle:
                    if (!line_level)
                        rx_state <= uart_state_pkg::rx_start;    // falling edge
                uart_state_pkg::rx_start:
                begin
                    rx_bit_cnt <= '0;
                    if (rx_mid_tick)
                    begin
                        if (line_level)
                            rx_state <= uart_state_pkg::rx_idle;  // glitch, not a start bit
                        else
                            rx_state <= uart_state_pkg::rx_data;
                    end
                end
                uart_state_pkg::rx_data:
                begin
                    if (rx_mid_tick)
                    begin
                        rx_bit_cnt <= rx_bit_cnt + 1'b1;
                        if (rx_bit_cnt == RX_LAST_DATA)
                        begin
                            if (HAS_PARITY)
                                rx_state <= uart_state_pkg::rx_parity;
                            else
                                rx_state <= uart_state_pkg::rx_stop;
                        end
                    end
                end
                uart_state_pkg::rx_parity:
                    if (rx_mid_tick)
                        rx_state <= uart_state_pkg::rx_stop;
                default:
                    if (rx_mid_tick)
                        rx_state <= uart_state_pkg::rx_idle;     // judged, rearm at once
            endcase
        end
    end

    ////////////////////
    // protocol checks

    // the user holds tx_valid until it sees the accept
    a_accept_with_valid : assert property (
        @(posedge clk) disable iff (rst)
        tx_valid && !tx_accept |=> tx_valid || tx_accept
    );

    // the tx timer only runs while a frame is on the line
    a_tx_timer_in_frame : assert property (
        @(posedge clk) disable iff (rst)
        tx_mid_tick |-> (tx_state == uart_state_pkg::tx_frame)
    );

endmodule

//--- source/uart_settings.svh
// UART frame settings
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

////////////////////
// serial timing
`define UART_CLKS_PER_BIT 16            // clocks per bit, kept small for simulation

////////////////////
// frame format
`define UART_DATA_BITS 8

`define UART_PARITY_NONE 0
`define UART_PARITY_EVEN 1
`define UART_PARITY_ODD 2
`define UART_PARITY_MODE `UART_PARITY_EVEN

`define UART_STOP_BITS 1                // 1 or 2

// start + data + optional parity + stop
`define UART_PARITY_BITS ((`UART_PARITY_MODE == `UART_PARITY_NONE) ? 0 : 1)
`define UART_FRAME_BITS (1 + `UART_DATA_BITS + `UART_PARITY_BITS + `UART_STOP_BITS)

////////////////////
// receive buffer
`define UART_FIFO_DEPTH 16              // power of two, pointers wrap on their own

`endif

//--- source/uart_state_pkg.sv
// UART state machine encodings
package uart_state_pkg;

    ////////////////////
    // transmitter

    typedef enum logic [1:0]
    {
        tx_idle,        // waiting for tx_valid
        tx_frame,       // bits going out on the line
        tx_done         // one cycle after the last stop bit
    } tx_state_t;

    ////////////////////
    // receiver

    typedef enum logic [2:0]
    {
        rx_idle,        // line high, watching for the start edge
        rx_start,       // start bit, confirmed at its middle
        rx_data,        // data bits, LSB first
        rx_parity,      // parity bit when enabled
        rx_stop         // first stop bit, frame judged here
    } rx_state_t;

endpackage

//--- source/uart_top.sv
// RS-232 UART top level

module uart_top
(
    input  logic                  clk,
    input  logic                  rst,
    // serial lines
    input  logic                  rx,
    output logic                  tx,
    // transmit side
    input  logic                  tx_valid,
    input  uart_types_pkg::data_t tx_data,
    output logic                  tx_accept,
    output logic                  tx_busy,
    // receive side
    input  logic                  rx_read,
    output logic                  rx_valid,
    output uart_types_pkg::data_t rx_data,
    output logic                  rx_err,
    output logic                  rx_overflow
);

    logic                  tx_run;
    logic                  tx_load;
    logic                  tx_shift;
    logic                  tx_mid_tick;
    logic                  tx_end_tick;
    logic                  rx_run;
    logic                  rx_mid_tick;
    logic                  line_level;
    logic                  sample_data;
    logic                  sample_parity;
    logic                  sample_stop;
    logic                  byte_valid;
    uart_types_pkg::data_t rx_byte;

    ////////////////////
    // sequencing

    uart_control uart_control_inst
    (
        .clk           (clk),
        .rst           (rst),
        .tx_valid      (tx_valid),
        .tx_accept     (tx_accept),
        .tx_busy       (tx_busy),
        .tx_run        (tx_run),
        .tx_load       (tx_load),
        .tx_shift      (tx_shift),
        .tx_mid_tick   (tx_mid_tick),
        .tx_end_tick   (tx_end_tick),
        .rx_run        (rx_run),
        .rx_mid_tick   (rx_mid_tick),
        .line_level    (line_level),
        .sample_data   (sample_data),
        .sample_parity (sample_parity),
        .sample_stop   (sample_stop)
    );

    bit_timer tx_timer
    (
        .clk      (clk),
        .rst      (rst),
        .run      (tx_run),
        .mid_tick (tx_mid_tick),
        .end_tick (tx_end_tick)
    );

    // receiver works on mid-bit strobes only
    bit_timer rx_timer
    (
        .clk      (clk),
        .rst      (rst),
        .run      (rx_run),
        .mid_tick (rx_mid_tick),
        .end_tick ()
    );

    ////////////////////
    // datapath

    tx_serializer tx_serializer_inst
    (
        .clk   (clk),
        .rst   (rst),
        .load  (tx_load),
        .shift (tx_shift),
        .data  (tx_data),
        .tx    (tx)
    );

    rx_deserializer rx_deserializer_inst
    (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .sample_data   (sample_data),
        .sample_parity (sample_parity),
        .sample_stop   (sample_stop),
        .line_level    (line_level),
        .data          (rx_byte),
        .byte_valid    (byte_valid),
        .frame_err     (rx_err)
    );

    rx_fifo rx_fifo_inst
    (
        .clk       (clk),
        .rst       (rst),
        .push      (byte_valid),
        .push_data (rx_byte),
        .pop       (rx_read),
        .head_data (rx_data),
        .not_empty (rx_valid),
        .overflow  (rx_overflow)
    );

endmodule

//--- source/uart_types_pkg.sv
// UART datapath types
`include "uart_settings.svh"

package uart_types_pkg;

    ////////////////////
    // payload

    // one serial data word
    typedef logic [`UART_DATA_BITS-1:0] data_t;

    ////////////////////
    // counters

    // clock count inside one bit period
    typedef logic [$clog2(`UART_CLKS_PER_BIT)-1:0] tick_count_t;

    // bit index inside a frame, up to 12 bits per frame
    typedef logic [3:0] bit_count_t;

    // read and write pointers of the receive buffer
    typedef logic [$clog2(`UART_FIFO_DEPTH)-1:0] fifo_addr_t;

endpackage

//--- testbench/tb_clock_gen.sv
// testbench clock and reset
module tb_clock_gen
(
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam time HALF_PERIOD = 20ns;     // 40 ns period
    localparam int  RESET_CYCLES = 5;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a falling edge, like the rest of the stimulus
    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- testbench/tb_uart_top.sv
// UART directed testbench
`include "uart_settings.svh"

module tb_uart_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLKS        = `UART_CLKS_PER_BIT;
    localparam int DATA_BITS   = `UART_DATA_BITS;
    localparam int PARITY_BITS = `UART_PARITY_BITS;
    localparam int FRAME_BITS  = `UART_FRAME_BITS;
    localparam int STOP_POS    = 1 + DATA_BITS + PARITY_BITS;   // first stop bit
    localparam int DEPTH       = `UART_FIFO_DEPTH;
    // about 30 frames of 176 clocks plus idle gaps, with a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic                  clk;
    logic                  rst;
    logic                  rx;
    logic                  tx;
    logic                  tx_valid;
    uart_types_pkg::data_t tx_data;
    logic                  tx_accept;
    logic                  tx_busy;
    logic                  rx_read;
    logic                  rx_valid;
    uart_types_pkg::data_t rx_data;
    logic                  rx_err;
    logic                  rx_overflow;

    int          errors       = 0;
    int          cycle_count  = 0;
    int          accept_count = 0;
    int          err_count    = 0;
    int          ovf_count    = 0;
    logic [31:0] rng_state    = 32'h823e;

    tb_clock_gen clock_gen_inst
    (
        .clk (clk),
        .rst (rst)
    );

    uart_top uart_top_inst
    (
        .clk         (clk),
        .rst         (rst),
        .rx          (rx),
        .tx          (tx),
        .tx_valid    (tx_valid),
        .tx_data     (tx_data),
        .tx_accept   (tx_accept),
        .tx_busy     (tx_busy),
        .rx_read     (rx_read),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .rx_err      (rx_err),
        .rx_overflow (rx_overflow)
    );

    ////////////////////
    // monitors and watchdog

    // strobes counted at the rising edge, read by the tests at falling edges
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (tx_accept)
                accept_count++;
            if (rx_err)
                err_count++;
            if (rx_overflow)
                ovf_count++;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, %0d errors so far", cycle_count, errors);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////
    // helpers

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("error: %s", what);
        errors++;
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_byte(output uart_types_pkg::data_t b);
        rng_state = xorshift32(rng_state);
        b = rng_state[DATA_BITS-1:0];
    endtask

    // parity bit that brings the count of ones to the configured sense
    function automatic logic parity_of(input uart_types_pkg::data_t d);
        int ones;
        int i;
        ones = 0;
        for (i = 0; i < DATA_BITS; i++)
            ones += d[i];
        if (`UART_PARITY_MODE == `UART_PARITY_ODD)
            return (ones % 2) == 0;
        else
            return (ones % 2) == 1;
    endfunction

    task automatic idle_line(input int bit_times);
        rx = 1'b1;
        repeat (bit_times * CLKS) @(negedge clk);
    endtask

    // serial line model, one bit every CLKS cycles, LSB first
    task automatic drive_rx_frame(input uart_types_pkg::data_t d, input logic flip_parity,
                                  input logic stop_level);
        logic [FRAME_BITS-1:0] bits;
        int                    i;
        bits = '1;
        bits[0] = 1'b0;
        bits[DATA_BITS:1] = d;
        if (PARITY_BITS == 1)
            bits[DATA_BITS+1] = parity_of(d) ^ flip_parity;
        bits[STOP_POS] = stop_level;
        for (i = 0; i < FRAME_BITS; i++)
        begin
            @(negedge clk);
            rx = bits[i];
            repeat (CLKS - 1) @(negedge clk);
        end
        @(negedge clk);
        rx = 1'b1;                          // back to idle
    endtask

    // waits for the start edge on tx, then samples each bit near its middle
    task automatic capture_tx_frame(output logic [FRAME_BITS-1:0] bits);
        int waited;
        int i;
        bits = '1;
        waited = 0;
        while (tx !== 1'b0 && waited < 4 * CLKS)
        begin
            @(negedge clk);
            waited++;
        end
        if (tx !== 1'b0)
        begin
            report_failure("no start bit appeared on tx");
            return;
        end
        repeat (CLKS / 2 - 1) @(negedge clk);
        for (i = 0; i < FRAME_BITS; i++)
        begin
            if (i > 0)
                repeat (CLKS) @(negedge clk);
            bits[i] = tx;
            if (tx_busy !== 1'b1)
                report_failure("tx_busy was low in the middle of a frame");
        end
        waited = 0;
        while (tx_busy !== 1'b0 && waited < CLKS + 4)
        begin
            @(negedge clk);
            waited++;
        end
        if (tx_busy !== 1'b0)
            report_failure("tx_busy did not fall after the frame");
    endtask

    task automatic send_tx_byte(input uart_types_pkg::data_t d);
        logic [FRAME_BITS-1:0] bits;
        int                    waited;
        int                    accepts_before;
        int                    i;
        waited = 0;
        while (tx_busy !== 1'b0 && waited < 2 * FRAME_BITS * CLKS)
        begin
            @(negedge clk);
            waited++;
        end
        accepts_before = accept_count;
        tx_data = d;
        tx_valid = 1'b1;
        waited = 0;
        @(negedge clk);
        while (tx_accept !== 1'b1 && waited < 4)
        begin
            @(negedge clk);
            waited++;
        end
        if (tx_accept !== 1'b1)
        begin
            report_failure("tx_accept never pulsed for a waiting byte");
            tx_valid = 1'b0;
            return;
        end
        if (tx_busy !== 1'b1)
            report_mismatch("tx_busy", 1, tx_busy);
        tx_valid = 1'b0;
        capture_tx_frame(bits);
        if (bits[0] !== 1'b0)
            report_mismatch("tx start bit", 0, bits[0]);
        if (bits[DATA_BITS:1] !== d)
            report_mismatch("tx data", d, bits[DATA_BITS:1]);
        if (PARITY_BITS == 1 && bits[DATA_BITS+1] !== parity_of(d))
            report_mismatch("tx parity bit", parity_of(d), bits[DATA_BITS+1]);
        for (i = STOP_POS; i < FRAME_BITS; i++)
        begin
            if (bits[i] !== 1'b1)
                report_mismatch("tx stop bit", 1, bits[i]);
        end
        if (accept_count - accepts_before != 1)
            report_mismatch("tx_accept pulses", 1, accept_count - accepts_before);
    endtask

    task automatic wait_for_rx_valid(output logic seen);
        int waited;
        waited = 0;
        while (rx_valid !== 1'b1 && waited < 2 * CLKS)
        begin
            @(negedge clk);
            waited++;
        end
        seen = (rx_valid === 1'b1);
    endtask

    // checks the head byte, then pops it with a one cycle strobe
    task automatic read_and_check(input uart_types_pkg::data_t expected);
        if (rx_valid !== 1'b1)
            report_failure("rx_valid was low where a byte should be waiting");
        else if (rx_data !== expected)
            report_mismatch("rx_data", expected, rx_data);
        rx_read = 1'b1;
        @(negedge clk);
        rx_read = 1'b0;
    endtask

    ////////////////////
    // directed tests

    task automatic check_reset_state;
        @(negedge clk);
        if (tx !== 1'b1)
            report_mismatch("tx", 1, tx);
        if (tx_busy !== 1'b0)
            report_mismatch("tx_busy", 0, tx_busy);
        if (tx_accept !== 1'b0)
            report_mismatch("tx_accept", 0, tx_accept);
        if (rx_valid !== 1'b0)
            report_mismatch("rx_valid", 0, rx_valid);
        if (rx_err !== 1'b0)
            report_mismatch("rx_err", 0, rx_err);
        if (rx_overflow !== 1'b0)
            report_mismatch("rx_overflow", 0, rx_overflow);
    endtask

    task automatic transmit_random_bytes(input int count);
        uart_types_pkg::data_t b;
        int                    i;
        for (i = 0; i < count; i++)
        begin
            draw_byte(b);
            send_tx_byte(b);
        end
    endtask

    task automatic receive_random_frames(input int count);
        uart_types_pkg::data_t b;
        logic                  seen;
        int                    errs_before;
        int                    i;
        errs_before = err_count;
        for (i = 0; i < count; i++)
        begin
            draw_byte(b);
            drive_rx_frame(b, 1'b0, 1'b1);
            wait_for_rx_valid(seen);
            if (!seen)
                report_failure("rx_valid did not rise after a good frame");
            else
                read_and_check(b);
            if (rx_valid !== 1'b0)
                report_mismatch("rx_valid after read", 0, rx_valid);
        end
        if (err_count != errs_before)
            report_mismatch("rx_err pulses", 0, err_count - errs_before);
    endtask

    task automatic reject_bad_parity;
        uart_types_pkg::data_t b;
        int                    errs_before;
        errs_before = err_count;
        draw_byte(b);
        drive_rx_frame(b, 1'b1, 1'b1);
        idle_line(2);
        if (err_count - errs_before != 1)
            report_mismatch("rx_err pulses on parity error", 1, err_count - errs_before);
        if (rx_valid !== 1'b0)
            report_mismatch("rx_valid after parity error", 0, rx_valid);
    endtask

    task automatic reject_bad_stop;
        uart_types_pkg::data_t b;
        int                    errs_before;
        errs_before = err_count;
        draw_byte(b);
        drive_rx_frame(b, 1'b0, 1'b0);
        idle_line(2);                       // lets the receiver rearm on a high line
        if (err_count - errs_before != 1)
            report_mismatch("rx_err pulses on framing error", 1, err_count - errs_before);
        if (rx_valid !== 1'b0)
            report_mismatch("rx_valid after framing error", 0, rx_valid);
    endtask

    task automatic fill_past_depth;
        uart_types_pkg::data_t b;
        uart_types_pkg::data_t sent [$];
        int                    ovf_before;
        int                    errs_before;
        int                    i;
        ovf_before = ovf_count;
        errs_before = err_count;
        for (i = 0; i < DEPTH + 2; i++)
        begin
            draw_byte(b);
            if (i < DEPTH)
                sent.push_back(b);          // the last two are dropped
            drive_rx_frame(b, 1'b0, 1'b1);
        end
        idle_line(1);
        if (ovf_count - ovf_before != 2)
            report_mismatch("rx_overflow pulses", 2, ovf_count - ovf_before);
        if (err_count != errs_before)
            report_mismatch("rx_err pulses", 0, err_count - errs_before);
        for (i = 0; i < sent.size(); i++)
            read_and_check(sent[i]);
        if (rx_valid !== 1'b0)
            report_mismatch("rx_valid after draining", 0, rx_valid);
    endtask

    ////////////////////
    // sequence

    initial
    begin
        rx = 1'b1;
        tx_valid = 1'b0;
        tx_data = '0;
        rx_read = 1'b0;
        wait (rst === 1'b0);
        check_reset_state();
        transmit_random_bytes(5);
        receive_random_frames(5);
        reject_bad_parity();
        reject_bad_stop();
        fill_past_depth();
        $display("finished after %0d cycles with %0d errors", cycle_count, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
